// ==== project.f ====
common/cachePkg.sv
cache/metaDataArray.sv
cache/dataArray.sv
cache/cacheCore.sv
source/fillController.sv
source/mainMemory.sv
source/memorySystem.sv
test/memorySystem_chk.sv
test/memorySystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module memorySystemTb \
   -f project.f -o simv &&
./obj_dir/simv 2>&1 | tee sim.log &&
! grep -q "Simulation finished: FAIL" sim.log &&
grep -q "Simulation finished: PASS" sim.log &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== test/memorySystemTb.sv ====
`timescale 1ns/10ps

module memorySystemTb
   import cachePkg::*;
();

   localparam int numSets = 64;
   localparam int latency = 4;
   localparam int numRequests = 2000;
   localparam int reqTimeout = 200;       // a write miss needs about 50 cycles.
   localparam int readyTimeout = 40000;   // the init sweep takes 32K cycles.

   logic clk = 1'b0;
   logic rst;
   cpuReq_s req;
   logic [dataWidth-1:0] dataOut;
   logic done, stall, ready;

   // --------------------------------------------------
   // reference model state
   // --------------------------------------------------
   logic [dataWidth-1:0] modelMem [logic [memAddrWidth-1:0]];   // only words written so far.
   logic modelValid [numSets][2];
   logic [tagWidth-1:0] modelTag [numSets][2];
   logic modelLru [numSets];
   logic [31:0] lfsr = 32'hc0d;
   int hitCount = 0;
   int missCount = 0;

   memorySystem #(.sets(numSets), .memLatency(latency)) memorySystem_i (
      .clk     (clk),
      .rst     (rst),
      .req     (req),
      .dataOut (dataOut),
      .done    (done),
      .stall   (stall),
      .ready   (ready)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] lfsrNext(input logic [31:0] state);
      logic [31:0] nextState;
      nextState = state >> 1;
      if (state[0]) nextState = nextState ^ 32'h80200003;   // Galois feedback taps.
      return nextState;
   endfunction

   task automatic takeBits(input int count, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr = lfsrNext(lfsr);
         value = {value[30:0], lfsr[0]};   // one LFSR step per bit.
      end
   endtask

   // Every backing word starts as its word address XOR 5a5a.
   function automatic logic [dataWidth-1:0] resetContent(input logic [memAddrWidth-1:0] wordAddr);
      return {1'b0, wordAddr} ^ 16'h5a5a;
   endfunction

   task automatic failRun(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] time %0t ns, %s: actual %0h, expected %0h",
                  $time, name, actual, expected);
         $display("Simulation finished: FAIL");
         $fatal(1, "check failed");
      end
   endtask

   task automatic waitReady();
      int waited;
      waited = 0;
      while (!ready && waited < readyTimeout) begin
         @(negedge clk);
         waited++;
      end
      if (!ready) failRun("main memory did not finish its init sweep");
   endtask

   // --------------------------------------------------
   // one CPU request, held until done
   // --------------------------------------------------
   task automatic runRequest(input logic wr, input logic [addrWidth-1:0] byteAddr,
                             input logic [dataWidth-1:0] data, output logic [dataWidth-1:0] rdData,
                             output int cycles, output logic stallFirst, output logic sawStall);
      logic gotDone;
      req.enable = 1'b1;
      req.wr = wr;
      req.addr.raw = byteAddr;
      req.dataIn = data;
      cycles = 0;
      gotDone = 1'b0;
      stallFirst = 1'b0;
      sawStall = 1'b0;
      while (!gotDone && cycles < reqTimeout) begin
         @(negedge clk);
         cycles++;
         if (cycles == 1) stallFirst = stall;
         if (done) gotDone = 1'b1;
         else if (stall) sawStall = 1'b1;   // stall seen in an earlier cycle than done.
      end
      if (!gotDone) failRun("request got no done pulse");
      rdData = dataOut;
      req.enable = 1'b0;
      @(negedge clk);   // one idle cycle so the core is back in idle.
   endtask

   task automatic accessAndCheck(input logic wr, input logic [tagWidth-1:0] tag,
                                 input logic [setWidth-1:0] set,
                                 input logic [wordSelWidth-1:0] wordSel,
                                 input logic [dataWidth-1:0] data);
      logic [memAddrWidth-1:0] wordAddr;
      logic predHit;
      logic way;
      logic [dataWidth-1:0] rdData;
      logic [dataWidth-1:0] expected;
      int cycles;
      logic stallFirst;
      logic sawStall;
      wordAddr = {tag, set, wordSel};
      predHit = 1'b0;
      way = 1'b0;
      for (int w = 0; w < 2; w++) begin
         if (modelValid[set][w] && modelTag[set][w] == tag) begin
            predHit = 1'b1;
            way = w[0];
         end
      end
      if (!predHit) begin
         if (!modelValid[set][0]) way = 1'b0;        // an empty way goes first.
         else if (!modelValid[set][1]) way = 1'b1;
         else way = modelLru[set];
      end
      runRequest(wr, {wordAddr, 1'b0}, data, rdData, cycles, stallFirst, sawStall);
      if (predHit) begin
         hitCount++;
         checkValue("stall during hit", 32'(sawStall), 32'd0);
         if (wr) checkValue("write hit latency", 32'(cycles), 32'(latency + 2));
         else checkValue("read hit latency", 32'(cycles), 32'd1);
      end else begin
         missCount++;
         checkValue("stall one cycle after enable on miss", 32'(stallFirst), 32'd1);
         checkValue("stall before done on miss", 32'(sawStall), 32'd1);
         modelValid[set][way] = 1'b1;
         modelTag[set][way] = tag;
      end
      modelLru[set] = ~way;   // the accessed way becomes the most recent.
      if (wr) begin
         modelMem[wordAddr] = data;
      end else begin
         if (modelMem.exists(wordAddr)) expected = modelMem[wordAddr];
         else expected = resetContent(wordAddr);
         checkValue("dataOut", 32'(rdData), 32'(expected));
      end
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      logic [31:0] bits;
      logic [setWidth-1:0] set;
      logic [tagWidth-1:0] tag;
      logic [wordSelWidth-1:0] wordSel;
      logic wr;
      logic [dataWidth-1:0] data;
      rst = 1'b1;
      req = '0;
      for (int s = 0; s < numSets; s++) begin
         modelValid[s][0] = 1'b0;
         modelValid[s][1] = 1'b0;
         modelTag[s][0] = '0;
         modelTag[s][1] = '0;
         modelLru[s] = 1'b0;
      end
      repeat (4) @(negedge clk);
      rst = 1'b0;
      waitReady();
      checkValue("done after reset", 32'(done), 32'd0);
      checkValue("stall after reset", 32'(stall), 32'd0);
      for (int s = 0; s < numSets; s++) begin   // first touch of every set.
         takeBits(wordSelWidth, bits);
         accessAndCheck(1'b0, '0, s[setWidth-1:0], bits[wordSelWidth-1:0], '0);
      end
      for (int n = 0; n < numRequests; n++) begin
         takeBits(setWidth, bits);
         set = bits[setWidth-1:0];
         takeBits(2, bits);
         tag = {set[3:0], bits[1:0]};   // four tags share each set.
         takeBits(wordSelWidth, bits);
         wordSel = bits[wordSelWidth-1:0];
         takeBits(1, bits);
         wr = bits[0];
         takeBits(dataWidth, bits);
         data = bits[dataWidth-1:0];
         accessAndCheck(wr, tag, set, wordSel, data);
      end
      $display("requests %0d, hits %0d, misses %0d", numRequests + numSets, hitCount, missCount);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== test/memorySystem_chk.sv ====
`timescale 1ns/10ps

module memorySystem_chk (
   input logic clk,
   input logic rst,
   input logic done,
   input logic stall,
   input logic memRd,
   input logic memWr
);

   // done is a one-cycle pulse.
   doneSingle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else $error("done was high for two cycles in a row");

   stallDone: assert property (@(posedge clk) disable iff (rst) !(stall && done))
      else $error("stall and done were high together");

   // the memory port takes one command at a time.
   memCmd: assert property (@(posedge clk) disable iff (rst) !(memRd && memWr))
      else $error("memory rd and wr were high together");

endmodule

bind memorySystem memorySystem_chk chk_i (
   .clk   (clk),
   .rst   (rst),
   .done  (done),
   .stall (stall),
   .memRd (memReq.rd),
   .memWr (memReq.wr)
);

// ==== source/memorySystem.sv ====
`timescale 1ns/10ps

module memorySystem
   import cachePkg::*;
#(
   parameter int sets = 2 ** setWidth,
   parameter int memLatency = cachePkg::memLatency
) (
   input  logic                   clk,
   input  logic                   rst,
   input  cpuReq_s                req,
   output logic [dataWidth-1:0]   dataOut,
   output logic                   done,
   output logic                   stall,
   output logic                   ready
);

   // --------------------------------------------------
   // cache to fill controller
   // --------------------------------------------------
   logic fillStart, storeReq;
   logic [memAddrWidth-1:0] blockAddr, storeAddr;
   logic [dataWidth-1:0] storeData;
   logic fillWe, fillDone, storeDone;
   logic [wordSelWidth-1:0] fillIdx;
   logic [dataWidth-1:0] fillWord;

   memReq_s memReq;   // fill controller to main memory.
   memRsp_s memRsp;

   cacheCore #(.sets(sets)) cacheCore_i (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .dataOut   (dataOut),
      .done      (done),
      .stall     (stall),
      .fillStart (fillStart),
      .storeReq  (storeReq),
      .blockAddr (blockAddr),
      .storeAddr (storeAddr),
      .storeData (storeData),
      .fillWe    (fillWe),
      .fillIdx   (fillIdx),
      .fillWord  (fillWord),
      .fillDone  (fillDone),
      .storeDone (storeDone)
   );

   fillController #(.memLatency(memLatency)) fillController_i (
      .clk       (clk),
      .rst       (rst),
      .fillStart (fillStart),
      .blockAddr (blockAddr),
      .storeReq  (storeReq),
      .storeAddr (storeAddr),
      .storeData (storeData),
      .fillWe    (fillWe),
      .fillIdx   (fillIdx),
      .fillWord  (fillWord),
      .fillDone  (fillDone),
      .storeDone (storeDone),
      .memReq    (memReq),
      .memRsp    (memRsp)
   );

   mainMemory #(.memLatency(memLatency)) mainMemory_i (
      .clk      (clk),
      .rst      (rst),
      .memReq   (memReq),
      .memRsp   (memRsp),
      .initDone (ready)   // low until every word holds its reset content.
   );

endmodule

// ==== source/mainMemory.sv ====
`timescale 1ns/10ps

module mainMemory
   import cachePkg::*;
#(
   parameter int memLatency = cachePkg::memLatency
) (
   input  logic      clk,
   input  logic      rst,
   input  memReq_s   memReq,
   output memRsp_s   memRsp,
   output logic      initDone
);

   localparam int depth = 1 << memAddrWidth;
   localparam int cntWidth = $clog2(memLatency + 1);

   logic [dataWidth-1:0] mem [depth];
   logic [memAddrWidth-1:0] sweepAddr;
   logic [cntWidth-1:0] count;
   logic [memAddrWidth-1:0] addrQ;
   logic [dataWidth-1:0] dataQ;
   logic wrQ;
   logic accept;

   assign accept = initDone && (memReq.rd || memReq.wr);   // ignored during the sweep.

   // --------------------------------------------------
   // init sweep and access countdown
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         sweepAddr <= '0;
         initDone <= 1'b0;
         count <= '0;
         wrQ <= 1'b0;
      end else begin
         if (!initDone) begin
            sweepAddr <= sweepAddr + 1'b1;
            if (&sweepAddr) initDone <= 1'b1;
         end
         if (accept) begin
            count <= cntWidth'(memLatency);
            wrQ <= memReq.wr;
         end else if (count != '0) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addrQ <= memReq.addr;
         dataQ <= memReq.wrData;
      end
   end

   always_ff @(posedge clk) begin
      if (!initDone) mem[sweepAddr] <= initWord(sweepAddr);
      else if (memRsp.done && wrQ) mem[addrQ] <= dataQ;   // the store lands with done.
   end

   assign memRsp.done = (count == cntWidth'(1));
   assign memRsp.rdData = mem[addrQ];

endmodule

// ==== source/fillController.sv ====
`timescale 1ns/10ps

module fillController
   import cachePkg::*;
#(
   parameter int memLatency = cachePkg::memLatency
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      fillStart,
   input  logic [memAddrWidth-1:0]   blockAddr,
   input  logic                      storeReq,
   input  logic [memAddrWidth-1:0]   storeAddr,
   input  logic [dataWidth-1:0]      storeData,
   output logic                      fillWe,
   output logic [wordSelWidth-1:0]   fillIdx,
   output logic [dataWidth-1:0]      fillWord,
   output logic                      fillDone,
   output logic                      storeDone,
   output memReq_s                   memReq,
   input  memRsp_s                   memRsp
);

   localparam int cntWidth = $clog2(memLatency + 1);

   typedef enum logic [1:0] {fcIdle, fcWaitRd, fcWaitWr} fcState_e;

   fcState_e state;
   logic rdQ, wrQ;
   logic [memAddrWidth-1:0] addrQ;
   logic [dataWidth-1:0] dataQ;
   logic [wordSelWidth-1:0] idxQ;
   logic [cntWidth-1:0] waitCnt;
   logic rspOk;

   // A reply counts only once the command's full latency has run out.
   assign rspOk = memRsp.done && (waitCnt == '0);

   // --------------------------------------------------
   // command sequencing
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= fcIdle;
         rdQ <= 1'b0;
         wrQ <= 1'b0;
         idxQ <= '0;
         waitCnt <= '0;
      end else begin
         rdQ <= 1'b0;   // commands are single-cycle pulses.
         wrQ <= 1'b0;
         if (waitCnt != '0) waitCnt <= waitCnt - 1'b1;
         case (state)
            fcIdle: begin
               if (fillStart) begin
                  rdQ <= 1'b1;
                  idxQ <= '0;
                  waitCnt <= cntWidth'(memLatency);
                  state <= fcWaitRd;
               end else if (storeReq) begin
                  wrQ <= 1'b1;
                  waitCnt <= cntWidth'(memLatency);
                  state <= fcWaitWr;
               end
            end
            fcWaitRd: begin
               if (rspOk) begin
                  idxQ <= idxQ + 1'b1;
                  if (&idxQ) begin
                     state <= fcIdle;   // last word of the block.
                  end else begin
                     rdQ <= 1'b1;
                     waitCnt <= cntWidth'(memLatency);
                  end
               end
            end
            fcWaitWr: if (rspOk) state <= fcIdle;
            default: state <= fcIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == fcIdle && fillStart) begin
         addrQ <= blockAddr;   // word 0 of the block.
      end else if (state == fcIdle && storeReq) begin
         addrQ <= storeAddr;
         dataQ <= storeData;
      end else if (fillWe && !fillDone) begin
         addrQ <= {addrQ[memAddrWidth-1:wordSelWidth], idxQ + 1'b1};
      end
   end

   assign memReq.rd = rdQ;
   assign memReq.wr = wrQ;
   assign memReq.addr = addrQ;
   assign memReq.wrData = dataQ;

   assign fillWe = (state == fcWaitRd) && rspOk;
   assign fillIdx = idxQ;
   assign fillWord = memRsp.rdData;
   assign fillDone = fillWe && (&idxQ);
   assign storeDone = (state == fcWaitWr) && rspOk;

endmodule

// ==== cache/cacheCore.sv ====
`timescale 1ns/10ps

module cacheCore
   import cachePkg::*;
#(
   parameter int sets = 2 ** setWidth
) (
   input  logic                      clk,
   input  logic                      rst,
   input  cpuReq_s                   req,
   output logic [dataWidth-1:0]      dataOut,
   output logic                      done,
   output logic                      stall,
   output logic                      fillStart,
   output logic                      storeReq,
   output logic [memAddrWidth-1:0]   blockAddr,
   output logic [memAddrWidth-1:0]   storeAddr,
   output logic [dataWidth-1:0]      storeData,
   input  logic                      fillWe,
   input  logic [wordSelWidth-1:0]   fillIdx,
   input  logic [dataWidth-1:0]      fillWord,
   input  logic                      fillDone,
   input  logic                      storeDone
);

   typedef enum logic [2:0] {stIdle, stLookup, stFill, stStore, stRespond} state_e;

   state_e state, stateNext;
   cacheAddr_u addr;
   logic [1:0] valid;
   logic [tagWidth-1:0] tag0, tag1;
   logic lru;
   logic hit0, hit1, hit, hitWay;
   logic victim, victimQ;
   logic decide;
   logic [1:0] wayWe;
   logic lruWe;
   logic arrWe, arrWay;
   logic [wordSelWidth-1:0] arrWordSel;
   logic [dataWidth-1:0] arrDataIn;

   assign addr = req.addr;

   // --------------------------------------------------
   // tag compare and way choice
   // --------------------------------------------------
   assign hit0 = valid[0] && (tag0 == addr.fields.tag);
   assign hit1 = valid[1] && (tag1 == addr.fields.tag);
   assign hit = hit0 || hit1;
   assign hitWay = hit1;   // both ways never hold the same tag.

   // an empty way is taken before the LRU way.
   assign victim = !valid[0] ? 1'b0 : (!valid[1] ? 1'b1 : lru);

   // A request is resolved on its first idle cycle, or again after a refill.
   assign decide = (state == stIdle && req.enable) || state == stLookup;
   assign fillStart = decide && !hit;
   assign storeReq = decide && hit && req.wr;   // write-through of a write hit.
   assign lruWe = decide && hit;
   assign wayWe = (state == stFill && fillDone) ? (victimQ ? 2'b10 : 2'b01) : 2'b00;

   // The refill owns the data array while it runs.
   assign arrWe = (state == stFill) ? fillWe : storeReq;
   assign arrWay = (state == stFill) ? victimQ : hitWay;
   assign arrWordSel = (state == stFill) ? fillIdx : addr.fields.wordSel;
   assign arrDataIn = (state == stFill) ? fillWord : req.dataIn;

   metaDataArray #(.sets(sets)) metaDataArray_i (
      .clk   (clk),
      .rst   (rst),
      .set   (addr.fields.set),
      .wayWe (wayWe),
      .tagIn (addr.fields.tag),
      .lruWe (lruWe),
      .lruIn (~hitWay),
      .valid (valid),
      .tag0  (tag0),
      .tag1  (tag1),
      .lru   (lru)
   );

   dataArray #(.sets(sets)) dataArray_i (
      .clk     (clk),
      .set     (addr.fields.set),
      .way     (arrWay),
      .wordSel (arrWordSel),
      .we      (arrWe),
      .dataIn  (arrDataIn),
      .dataOut (dataOut)
   );

   // --------------------------------------------------
   // request sequencing
   // --------------------------------------------------
   always_comb begin
      stateNext = state;
      case (state)
         stIdle, stLookup: begin
            if (decide) begin
               if (!hit) stateNext = stFill;
               else if (req.wr) stateNext = stStore;
               else stateNext = stRespond;
            end
         end
         stFill: if (fillDone) stateNext = stLookup;     // retry, now as a hit.
         stStore: if (storeDone) stateNext = stRespond;
         default: stateNext = stIdle;                    // respond lasts one cycle.
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) state <= stIdle;
      else state <= stateNext;
   end

   always_ff @(posedge clk) begin
      if (fillStart) victimQ <= victim;
   end

   assign done = (state == stRespond);
   assign stall = (state == stFill) || (state == stLookup);
   assign blockAddr = {addr.fields.tag, addr.fields.set, {wordSelWidth{1'b0}}};
   assign storeAddr = addr.raw[addrWidth-1:1];
   assign storeData = req.dataIn;

endmodule

// ==== cache/dataArray.sv ====
`timescale 1ns/10ps

module dataArray
   import cachePkg::*;
#(
   parameter int sets = 64
) (
   input  logic                      clk,
   input  logic [$clog2(sets)-1:0]   set,
   input  logic                      way,
   input  logic [wordSelWidth-1:0]   wordSel,
   input  logic                      we,
   input  logic [dataWidth-1:0]      dataIn,
   output logic [dataWidth-1:0]      dataOut
);

   localparam int idxWidth = $clog2(sets) + 1 + wordSelWidth;
   localparam int depth = sets * 2 * (1 << wordSelWidth);

   // --------------------------------------------------
   // word storage, one entry per set, way and word
   // --------------------------------------------------
   logic [dataWidth-1:0] mem [depth];
   logic [idxWidth-1:0] idx;

   // The set, way and word fields concatenate into a flat word index,
   // so each block is eight consecutive entries.
   assign idx = {set, way, wordSel};

   always_ff @(posedge clk) begin
      if (we) mem[idx] <= dataIn;   // one word per write.
   end

   assign dataOut = mem[idx];   // combinational read of the selected word.

endmodule

// ==== cache/metaDataArray.sv ====
`timescale 1ns/10ps

module metaDataArray
   import cachePkg::*;
#(
   parameter int sets = 64
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [$clog2(sets)-1:0]   set,
   input  logic [1:0]                wayWe,
   input  logic [tagWidth-1:0]       tagIn,
   input  logic                      lruWe,
   input  logic                      lruIn,
   output logic [1:0]                valid,
   output logic [tagWidth-1:0]       tag0,
   output logic [tagWidth-1:0]       tag1,
   output logic                      lru
);

   logic [1:0][sets-1:0] validQ;           // one valid bit per way and set.
   logic [sets-1:0] lruQ;                  // 0 evicts way 0, 1 evicts way 1.
   logic [tagWidth-1:0] tagMem [2][sets];

   always_ff @(posedge clk) begin
      if (rst) begin
         validQ <= '0;
         lruQ <= '0;
      end else begin
         for (int w = 0; w < 2; w++) begin
            if (wayWe[w]) validQ[w][set] <= 1'b1;   // a finished fill validates the way.
         end
         if (lruWe) lruQ[set] <= lruIn;
      end
   end

   always_ff @(posedge clk) begin
      for (int w = 0; w < 2; w++) begin
         if (wayWe[w]) tagMem[w][set] <= tagIn;
      end
   end

   assign valid = {validQ[1][set], validQ[0][set]};
   assign tag0 = tagMem[0][set];
   assign tag1 = tagMem[1][set];
   assign lru = lruQ[set];

endmodule

// ==== common/cachePkg.sv ====
package cachePkg;

   // --------------------------------------------------
   // address fields
   // --------------------------------------------------
   localparam int tagWidth = 6;
   localparam int setWidth = 6;
   localparam int wordSelWidth = 3;
   localparam int addrWidth = tagWidth + setWidth + wordSelWidth + 1;   // byte address.
   localparam int memAddrWidth = addrWidth - 1;                         // word address.
   localparam int dataWidth = 16;

   localparam int memLatency = 4;   // cycles from command to done.

   // The core reads the same CPU address as a plain word and as its fields.
   typedef union packed {
      logic [addrWidth-1:0] raw;
      struct packed {
         logic [tagWidth-1:0] tag;
         logic [setWidth-1:0] set;
         logic [wordSelWidth-1:0] wordSel;   // word within the 16-byte block.
         logic byteBit;                      // always zero for word accesses.
      } fields;
   } cacheAddr_u;

   // --------------------------------------------------
   // port bundles
   // --------------------------------------------------
   typedef struct packed {
      logic enable;
      logic wr;
      cacheAddr_u addr;
      logic [dataWidth-1:0] dataIn;
   } cpuReq_s;

   typedef struct packed {
      logic rd;
      logic wr;
      logic [memAddrWidth-1:0] addr;
      logic [dataWidth-1:0] wrData;
   } memReq_s;

   typedef struct packed {
      logic done;
      logic [dataWidth-1:0] rdData;
   } memRsp_s;

   // Reset content of one main-memory word.
   function automatic logic [dataWidth-1:0] initWord(input logic [memAddrWidth-1:0] wordAddr);
      return {{(dataWidth - memAddrWidth){1'b0}}, wordAddr} ^ 16'h5a5a;
   endfunction

endpackage
